/* rtl/alarm_overlay_pkg.sv */
`default_nettype none

package alarm_overlay_pkg;

        // display coordinate as produced by the pixel counter
        localparam int coord_w = 10;
        typedef logic [coord_w-1:0] coord_t;

        // square warning image, one bit per pixel
        localparam int img_size = 256;
        localparam int img_idx_w = $clog2(img_size);
        typedef logic [img_idx_w-1:0] img_idx_t;
        typedef logic [img_size-1:0] img_row_t;   // leftmost pixel in the top bit

        // what each pipeline stage hands to the next one
        typedef struct packed {
                logic     active;   // alarm on and inside the window
                img_idx_t row;
                img_idx_t col;
        } pix_req_t;

        localparam string img_file = "alarm_image.mem";

endpackage

`default_nettype wire

/* rtl/overlay_window.sv */
`default_nettype none

module overlay_window #(
        parameter alarm_overlay_pkg::coord_t win_x0 = 10'd256,
        parameter alarm_overlay_pkg::coord_t win_y0 = 10'd0
) (
        input  logic                        reloj,
        input  logic                        rst_n,
        input  logic                        alarm,
        input  alarm_overlay_pkg::coord_t   h_pos,
        input  alarm_overlay_pkg::coord_t   v_pos,
        output alarm_overlay_pkg::pix_req_t win_req
);
        import alarm_overlay_pkg::*;

        // one past the last window coordinate, one bit wider so it cannot wrap
        localparam logic [coord_w:0] x_end = (coord_w + 1)'(win_x0 + img_size);
        localparam logic [coord_w:0] y_end = (coord_w + 1)'(win_y0 + img_size);

        logic   in_x;
        logic   in_y;
        logic   hit;
        coord_t rel_h;
        coord_t rel_v;

        always_comb begin
                in_x  = (h_pos >= win_x0) && ({1'b0, h_pos} < x_end);
                in_y  = (v_pos >= win_y0) && ({1'b0, v_pos} < y_end);
                hit   = alarm && in_x && in_y;   // the only place the alarm is looked at
                rel_h = h_pos - win_x0;
                rel_v = v_pos - win_y0;
        end

        always_ff @(posedge reloj) begin
                if (!rst_n) begin
                        win_req.active <= 1'b0;
                end else begin
                        win_req.active <= hit;
                end
                // image-relative position, only meaningful while active
                win_req.row <= rel_v[img_idx_w-1:0];
                win_req.col <= rel_h[img_idx_w-1:0];
        end

endmodule

`default_nettype wire

/* rtl/glyph_rom.sv */
`default_nettype none

module glyph_rom (
        input  logic                        reloj,
        input  logic                        rst_n,
        input  alarm_overlay_pkg::pix_req_t win_req,
        output alarm_overlay_pkg::pix_req_t row_req,
        output alarm_overlay_pkg::img_row_t row_bits
);
        import alarm_overlay_pkg::*;

        // one entry per image row, row 0 at the top of the window
        img_row_t rom [img_size];

        initial begin
                $readmemh(img_file, rom);
        end

        // synchronous read keeps the row and its request on the same edge
        always_ff @(posedge reloj) begin
                row_bits <= rom[win_req.row];
        end

        always_ff @(posedge reloj) begin
                if (!rst_n) begin
                        row_req.active <= 1'b0;
                end else begin
                        row_req.active <= win_req.active;
                end
                row_req.row <= win_req.row;
                row_req.col <= win_req.col;   // column travels with its row
        end

endmodule

`default_nettype wire

/* rtl/pixel_pick.sv */
`default_nettype none

module pixel_pick (
        input  logic                        reloj,
        input  logic                        rst_n,
        input  alarm_overlay_pkg::pix_req_t row_req,
        input  alarm_overlay_pkg::img_row_t row_bits,
        output logic                        pixel
);
        import alarm_overlay_pkg::*;

        img_idx_t bit_sel;
        logic     row_bit;

        // msb first, column 0 is the top bit of the row
        always_comb begin
                bit_sel = img_idx_t'(img_size - 1 - int'(row_req.col));
                row_bit = row_bits[bit_sel];
        end

        always_ff @(posedge reloj) begin
                if (!rst_n) begin
                        pixel <= 1'b0;
                end else if (row_req.active) begin
                        pixel <= row_bit;
                end else begin
                        pixel <= 1'b0;   // outside the window or alarm off
                end
        end

endmodule

`default_nettype wire

/* rtl/alarm_overlay.sv */
`default_nettype none

module alarm_overlay #(
        parameter alarm_overlay_pkg::coord_t win_x0 = 10'd256,
        parameter alarm_overlay_pkg::coord_t win_y0 = 10'd0
) (
        input  logic                      reloj,
        input  logic                      rst_n,
        input  logic                      alarm,
        input  alarm_overlay_pkg::coord_t h_pos,
        input  alarm_overlay_pkg::coord_t v_pos,
        output logic                      pixel
);
        import alarm_overlay_pkg::*;

        pix_req_t win_req;
        pix_req_t row_req;
        img_row_t row_bits;   // aligned with row_req

        // stage 1, window decode
        overlay_window #(
                .win_x0 (win_x0),
                .win_y0 (win_y0)
        ) u_window (
                .reloj   (reloj),
                .rst_n   (rst_n),
                .alarm   (alarm),
                .h_pos   (h_pos),
                .v_pos   (v_pos),
                .win_req (win_req)
        );

        // stage 2, row fetch
        glyph_rom u_rom (
                .reloj    (reloj),
                .rst_n    (rst_n),
                .win_req  (win_req),
                .row_req  (row_req),
                .row_bits (row_bits)
        );

        // stage 3, bit select
        pixel_pick u_pick (
                .reloj    (reloj),
                .rst_n    (rst_n),
                .row_req  (row_req),
                .row_bits (row_bits),
                .pixel    (pixel)
        );

endmodule

`default_nettype wire

/* bench/alarm_overlay_assertions.sv */
`default_nettype none

module alarm_overlay_assertions #(
        parameter alarm_overlay_pkg::coord_t win_x0 = 10'd256
) (
        input logic                      reloj,
        input logic                      rst_n,
        input logic                      alarm,
        input alarm_overlay_pkg::coord_t h_pos,
        input logic                      pixel
);
        timeunit 1ns;
        timeprecision 100ps;

        import alarm_overlay_pkg::*;

        // reset clears the output register at the same edge
        assert property (@(posedge reloj) !rst_n |=> !pixel)
                else $error("pixel not cleared after a reset edge");

        // pixel seen at edge n+3 was produced from inputs sampled at edge n
        assert property (@(posedge reloj) pixel |-> $past(alarm, 3))
                else $error("pixel high without the alarm three clocks earlier");

        assert property (@(posedge reloj) pixel |-> ($past(h_pos, 3) >= win_x0))
                else $error("pixel high left of the window");

endmodule

bind alarm_overlay alarm_overlay_assertions #(
        .win_x0 (win_x0)
) u_assertions (
        .reloj (reloj),
        .rst_n (rst_n),
        .alarm (alarm),
        .h_pos (h_pos),
        .pixel (pixel)
);

`default_nettype wire

/* bench/alarm_overlay_tb.sv */
`default_nettype none

module alarm_overlay_tb;
        timeunit 1ns;
        timeprecision 100ps;

        import alarm_overlay_pkg::*;

        localparam int clk_period = 100;
        localparam int win_x0     = 256;   // DUT default origin
        localparam int win_y0     = 0;
        localparam int n_random   = 400;

        typedef struct {
                coord_t h;
                coord_t v;
                logic   alarm;
                int     tag;
        } stim_t;

        typedef struct {
                int     tag;
                logic   exp;
                coord_t h;
                coord_t v;
                logic   a;
        } exp_t;

        logic   reloj;
        logic   rst_n;
        logic   alarm;
        coord_t h_pos;
        coord_t v_pos;
        logic   pixel;

        img_row_t    image [img_size];
        stim_t       table_q [$];
        exp_t        exp_q [$];
        logic [31:0] lfsr = 32'haed3_d14f;
        int          checks [7];
        int          errs [7];
        int          cur_tag = 1;
        string       names [7] = '{"flush", "reset", "out of window", "in-window image",
                                   "alarm off", "pipelining", "random sweep"};

        alarm_overlay DUT (
                .reloj (reloj),
                .rst_n (rst_n),
                .alarm (alarm),
                .h_pos (h_pos),
                .v_pos (v_pos),
                .pixel (pixel)
        );

        initial begin
                reloj = 1'b0;
                forever #(clk_period / 2) reloj = ~reloj;
        end

        // galois form, taps for x^32 + x^22 + x^2 + x + 1
        function automatic logic [31:0] rand_bits(input int n);
                logic [31:0] val;
                val = '0;
                for (int k = 0; k < n; k++) begin
                        lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
                        val  = {val[30:0], lfsr[0]};
                end
                return val;
        endfunction

        function automatic logic model_pixel(input coord_t h, input coord_t v, input logic a);
                int rel_h;
                int rel_v;
                rel_h = int'(h) - win_x0;
                rel_v = int'(v) - win_y0;
                if (!a || rel_h < 0 || rel_h >= img_size || rel_v < 0 || rel_v >= img_size)
                        return 1'b0;
                return image[rel_v][img_size - 1 - rel_h];   // column 0 is the msb
        endfunction

        task automatic add_row(input int h, input int v, input logic a, input int tag);
                table_q.push_back(stim_t'{h: coord_t'(h), v: coord_t'(v), alarm: a, tag: tag});
        endtask

        task automatic build_table();
                int rows [5] = '{'h00, 'h2d, 'h4e, 'ha6, 'he1};
                int cols [4] = '{0, 9, 128, 255};
                int outs [10][2] = '{'{255, 0}, '{255, 100}, '{512, 0}, '{512, 100},
                                     '{256, 256}, '{300, 256}, '{400, 900}, '{0, 0},
                                     '{1023, 1023}, '{600, 50}};
                foreach (outs[i]) add_row(outs[i][0], outs[i][1], 1'b1, 2);
                foreach (rows[r]) foreach (cols[c]) add_row(win_x0 + cols[c], rows[r], 1'b1, 3);
                foreach (rows[r]) foreach (cols[c]) add_row(win_x0 + cols[c], rows[r], 1'b0, 4);
                for (int c = 120; c < 140; c++)   // alarm drops for five columns mid-run
                        add_row(win_x0 + c, 'h30, !(c >= 130 && c < 135), 5);
        endtask

        task automatic finish_test(input int tag);
                if (checks[tag] > 0)
                        $display("test %0d %s: %0d checks, %0d errors",
                                 tag, names[tag], checks[tag], errs[tag]);
        endtask

        task automatic check_oldest();
                exp_t e;
                e = exp_q.pop_front();
                if (e.tag != cur_tag) begin
                        finish_test(cur_tag);
                        cur_tag = e.tag;
                end
                checks[e.tag]++;
                assert (pixel === e.exp) else begin
                        errs[e.tag]++;
                        $display("ERR %0t: %s h=%0d v=%0d alarm=%0b expected %0b got %b",
                                 $time, names[e.tag], e.h, e.v, e.a, e.exp, pixel);
                end
        endtask

        // output after edge n+3 is checked at the falling edge before n+4
        task automatic apply(input coord_t h, input coord_t v, input logic a,
                             input logic rst, input int tag);
                exp_t e;
                @(negedge reloj);
                check_oldest();
                rst_n = rst;
                h_pos = h;
                v_pos = v;
                alarm = a;
                e = '{tag: tag, exp: (rst ? model_pixel(h, v, a) : 1'b0), h: h, v: v, a: a};
                exp_q.push_back(e);
        endtask

        initial begin
                logic [31:0] rh;
                logic [31:0] rv;
                logic [31:0] ra;
                int          total_checks;
                int          total_errs;
                rst_n = 1'b0;
                alarm = 1'b0;
                h_pos = '0;
                v_pos = '0;
                $readmemh("rtl/alarm_image.mem", image);
                build_table();
                repeat (3) exp_q.push_back(exp_t'{tag: 1, exp: 1'b0, h: '0, v: '0, a: 1'b0});
                // a lit in-window pixel with the alarm on must not leak through reset
                apply(coord_t'(win_x0), coord_t'(win_y0), 1'b1, 1'b0, 1);
                apply(coord_t'(win_x0), coord_t'(win_y0), 1'b1, 1'b0, 1);
                repeat (3) apply('0, '0, 1'b0, 1'b1, 1);
                foreach (table_q[i])
                        apply(table_q[i].h, table_q[i].v, table_q[i].alarm, 1'b1, table_q[i].tag);
                for (int n = 0; n < n_random; n++) begin
                        rh = rand_bits(10);
                        rv = rand_bits(9);   // keeps about half the rows inside the window
                        ra = rand_bits(1);
                        apply(coord_t'(rh), coord_t'(rv), ra[0], 1'b1, 6);
                end
                repeat (3) apply('0, '0, 1'b0, 1'b1, 0);
                finish_test(cur_tag);
                total_checks = 0;
                total_errs   = 0;
                foreach (checks[t]) begin
                        total_checks += checks[t];
                        total_errs   += errs[t];
                end
                $display("done: %0d checks, %0d errors", total_checks, total_errs);
                if (total_errs == 0) begin
                        $display("TB PASSED");
                end else begin
                        $display("TB FAILED");
                end
                $finish;
        end

        initial begin
                int cycles;
                #1;
                cycles = table_q.size() + n_random + 20;
                #(cycles * clk_period);
                $display("timeout: the run did not finish within %0d clock cycles", cycles);
                $display("TB FAILED");
                $finish;
        end

endmodule

`default_nettype wire

/* rtl/alarm_image.mem */
// one image row per line, row 0 first; 64 hex digits, leftmost pixel in the top bit
ffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffff
ffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffff
8000000000000000000000000000000000000000000000000000000000000001
8000000000000000000000000000000000000000000000000000000000000001
8000000000000000000000000000000000000000000000000000000000000001
8000000000000000000000000000000000000000000000000000000000000001
8000000000000000000000000000000000000000000000000000000000000001
8000000000000000000000000000000000000000000000000000000000000001
8000000000000000000000000000000000000000000000000000000000000001
8000000000000000000000000000000000000000000000000000000000000001
8000000000000000000000000000000000000000000000000000000000000001
8000000000000000000000000000000000000000000000000000000000000001
8000000000000000000000000000000000000000000000000000000000000001
8000000000000000000000000000000000000000000000000000000000000001
8000000000000000000000000000000000000000000000000000000000000001
8000000000000000000000000000000000000000000000000000000000000001
8000000000000000000000000000000000000000000000000000000000000001
8000000000000000000000000000000000000000000000000000000000000001
8000000000000000000000000000000000000000000000000000000000000001
8000000000000000000000000000000000000000000000000000000000000001
8000000000000000000000000000000000000000000000000000000000000001
8000000000000000000000000000000000000000000000000000000000000001
8000000000000000000000000000000000000000000000000000000000000001
8000000000000000000000000000000000000000000000000000000000000001
8000000000000000000000000000000000000000000000000000000000000001
8000000000000000000000000000000000000000000000000000000000000001
8000000000000000000000000000000000000000000000000000000000000001
8000000000000000000000000000000000000000000000000000000000000001
8000000000000000000000000000000000000000000000000000000000000001
8000000000000000000000000000000000000000000000000000000000000001
8000000000000000000000000000000000000000000000000000000000000001
8000000000000000000000000000000000000000000000000000000000000001
800000000000000000000000000000ffff000000000000000000000000000001
800000000000000000000000000000ffff000000000000000000000000000001
800000000000000000000000000000ffff000000000000000000000000000001
800000000000000000000000000000ffff000000000000000000000000000001
800000000000000000000000000000ffff000000000000000000000000000001
800000000000000000000000000000ffff000000000000000000000000000001
800000000000000000000000000000ffff000000000000000000000000000001
800000000000000000000000000000ffff000000000000000000000000000001
800000000000000000000000000000ffff000000000000000000000000000001
800000000000000000000000000000ffff000000000000000000000000000001
800000000000000000000000000000ffff000000000000000000000000000001
800000000000000000000000000000ffff000000000000000000000000000001
800000000000000000000000000000ffff000000000000000000000000000001
800000000000000000000000000000ffff000000000000000000000000000001
800000000000000000000000000000ffff000000000000000000000000000001
800000000000000000000000000000ffff000000000000000000000000000001
800000000000000000000000000000ffff000000000000000000000000000001
800000000000000000000000000000ffff000000000000000000000000000001
800000000000000000000000000000ffff000000000000000000000000000001
800000000000000000000000000000ffff000000000000000000000000000001
800000000000000000000000000000ffff000000000000000000000000000001
800000000000000000000000000000ffff000000000000000000000000000001
800000000000000000000000000000ffff000000000000000000000000000001
800000000000000000000000000000ffff000000000000000000000000000001
800000000000000000000000000000ffff000000000000000000000000000001
800000000000000000000000000000ffff000000000000000000000000000001
800000000000000000000000000000ffff000000000000000000000000000001
800000000000000000000000000000ffff000000000000000000000000000001
800000000000000000000000000000ffff000000000000000000000000000001
800000000000000000000000000000ffff000000000000000000000000000001
800000000000000000000000000000ffff000000000000000000000000000001
800000000000000000000000000000ffff000000000000000000000000000001
a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5
a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5
a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5
a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5
a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5
a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5
a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5
a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5
a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5
a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5
a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5
a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5
a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5
a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5
a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5
a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5
a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5
a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5
a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5
a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5
a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5
a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5
a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5
a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5
a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5
a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5
a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5
a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5
a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5
a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5
a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5
a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5
800000000000000000000000000000ffff000000000000000000000000000001
800000000000000000000000000000ffff000000000000000000000000000001
800000000000000000000000000000ffff000000000000000000000000000001
800000000000000000000000000000ffff000000000000000000000000000001
800000000000000000000000000000ffff000000000000000000000000000001
800000000000000000000000000000ffff000000000000000000000000000001
800000000000000000000000000000ffff000000000000000000000000000001
800000000000000000000000000000ffff000000000000000000000000000001
800000000000000000000000000000ffff000000000000000000000000000001
800000000000000000000000000000ffff000000000000000000000000000001
800000000000000000000000000000ffff000000000000000000000000000001
800000000000000000000000000000ffff000000000000000000000000000001
800000000000000000000000000000ffff000000000000000000000000000001
800000000000000000000000000000ffff000000000000000000000000000001
800000000000000000000000000000ffff000000000000000000000000000001
800000000000000000000000000000ffff000000000000000000000000000001
800000000000000000000000000000ffff000000000000000000000000000001
800000000000000000000000000000ffff000000000000000000000000000001
800000000000000000000000000000ffff000000000000000000000000000001
800000000000000000000000000000ffff000000000000000000000000000001
800000000000000000000000000000ffff000000000000000000000000000001
800000000000000000000000000000ffff000000000000000000000000000001
800000000000000000000000000000ffff000000000000000000000000000001
800000000000000000000000000000ffff000000000000000000000000000001
800000000000000000000000000000ffff000000000000000000000000000001
800000000000000000000000000000ffff000000000000000000000000000001
800000000000000000000000000000ffff000000000000000000000000000001
800000000000000000000000000000ffff000000000000000000000000000001
800000000000000000000000000000ffff000000000000000000000000000001
800000000000000000000000000000ffff000000000000000000000000000001
800000000000000000000000000000ffff000000000000000000000000000001
800000000000000000000000000000ffff000000000000000000000000000001
800000000000000000000000000000ffff000000000000000000000000000001
800000000000000000000000000000ffff000000000000000000000000000001
800000000000000000000000000000ffff000000000000000000000000000001
800000000000000000000000000000ffff000000000000000000000000000001
800000000000000000000000000000ffff000000000000000000000000000001
800000000000000000000000000000ffff000000000000000000000000000001
800000000000000000000000000000ffff000000000000000000000000000001
800000000000000000000000000000ffff000000000000000000000000000001
800000000000000000000000000000ffff000000000000000000000000000001
800000000000000000000000000000ffff000000000000000000000000000001
800000000000000000000000000000ffff000000000000000000000000000001
800000000000000000000000000000ffff000000000000000000000000000001
800000000000000000000000000000ffff000000000000000000000000000001
800000000000000000000000000000ffff000000000000000000000000000001
800000000000000000000000000000ffff000000000000000000000000000001
800000000000000000000000000000ffff000000000000000000000000000001
800000000000000000000000000000ffff000000000000000000000000000001
800000000000000000000000000000ffff000000000000000000000000000001
800000000000000000000000000000ffff000000000000000000000000000001
800000000000000000000000000000ffff000000000000000000000000000001
800000000000000000000000000000ffff000000000000000000000000000001
800000000000000000000000000000ffff000000000000000000000000000001
800000000000000000000000000000ffff000000000000000000000000000001
800000000000000000000000000000ffff000000000000000000000000000001
800000000000000000000000000000ffff000000000000000000000000000001
800000000000000000000000000000ffff000000000000000000000000000001
800000000000000000000000000000ffff000000000000000000000000000001
800000000000000000000000000000ffff000000000000000000000000000001
800000000000000000000000000000ffff000000000000000000000000000001
800000000000000000000000000000ffff000000000000000000000000000001
800000000000000000000000000000ffff000000000000000000000000000001
800000000000000000000000000000ffff000000000000000000000000000001
800000000000000000000000000000ffff000000000000000000000000000001
800000000000000000000000000000ffff000000000000000000000000000001
800000000000000000000000000000ffff000000000000000000000000000001
800000000000000000000000000000ffff000000000000000000000000000001
800000000000000000000000000000ffff000000000000000000000000000001
800000000000000000000000000000ffff000000000000000000000000000001
800000000000000000000000000000ffff000000000000000000000000000001
800000000000000000000000000000ffff000000000000000000000000000001
800000000000000000000000000000ffff000000000000000000000000000001
800000000000000000000000000000ffff000000000000000000000000000001
800000000000000000000000000000ffff000000000000000000000000000001
800000000000000000000000000000ffff000000000000000000000000000001
800000000000000000000000000000ffff000000000000000000000000000001
800000000000000000000000000000ffff000000000000000000000000000001
800000000000000000000000000000ffff000000000000000000000000000001
800000000000000000000000000000ffff000000000000000000000000000001
800000000000000000000000000000ffff000000000000000000000000000001
800000000000000000000000000000ffff000000000000000000000000000001
800000000000000000000000000000ffff000000000000000000000000000001
800000000000000000000000000000ffff000000000000000000000000000001
800000000000000000000000000000ffff000000000000000000000000000001
800000000000000000000000000000ffff000000000000000000000000000001
800000000000000000000000000000ffff000000000000000000000000000001
800000000000000000000000000000ffff000000000000000000000000000001
800000000000000000000000000000ffff000000000000000000000000000001
800000000000000000000000000000ffff000000000000000000000000000001
800000000000000000000000000000ffff000000000000000000000000000001
800000000000000000000000000000ffff000000000000000000000000000001
800000000000000000000000000000ffff000000000000000000000000000001
800000000000000000000000000000ffff000000000000000000000000000001
800000000000000000000000000000ffff000000000000000000000000000001
800000000000000000000000000000ffff000000000000000000000000000001
8000000000000000000000000000000000000000000000000000000000000001
8000000000000000000000000000000000000000000000000000000000000001
8000000000000000000000000000000000000000000000000000000000000001
8000000000000000000000000000000000000000000000000000000000000001
8000000000000000000000000000000000000000000000000000000000000001
8000000000000000000000000000000000000000000000000000000000000001
8000000000000000000000000000000000000000000000000000000000000001
8000000000000000000000000000000000000000000000000000000000000001
8000000000000000000000000000000000000000000000000000000000000001
8000000000000000000000000000000000000000000000000000000000000001
8000000000000000000000000000000000000000000000000000000000000001
8000000000000000000000000000000000000000000000000000000000000001
8000000000000000000000000000000000000000000000000000000000000001
8000000000000000000000000000000000000000000000000000000000000001
8000000000000000000000000000000000000000000000000000000000000001
8000000000000000000000000000000000000000000000000000000000000001
800000000000000000000000000000ffff000000000000000000000000000001
800000000000000000000000000000ffff000000000000000000000000000001
800000000000000000000000000000ffff000000000000000000000000000001
800000000000000000000000000000ffff000000000000000000000000000001
800000000000000000000000000000ffff000000000000000000000000000001
800000000000000000000000000000ffff000000000000000000000000000001
800000000000000000000000000000ffff000000000000000000000000000001
800000000000000000000000000000ffff000000000000000000000000000001
800000000000000000000000000000ffff000000000000000000000000000001
800000000000000000000000000000ffff000000000000000000000000000001
800000000000000000000000000000ffff000000000000000000000000000001
800000000000000000000000000000ffff000000000000000000000000000001
800000000000000000000000000000ffff000000000000000000000000000001
800000000000000000000000000000ffff000000000000000000000000000001
800000000000000000000000000000ffff000000000000000000000000000001
800000000000000000000000000000ffff000000000000000000000000000001
800000000000000000000000000000ffff000000000000000000000000000001
800000000000000000000000000000ffff000000000000000000000000000001
800000000000000000000000000000ffff000000000000000000000000000001
800000000000000000000000000000ffff000000000000000000000000000001
800000000000000000000000000000ffff000000000000000000000000000001
800000000000000000000000000000ffff000000000000000000000000000001
800000000000000000000000000000ffff000000000000000000000000000001
800000000000000000000000000000ffff000000000000000000000000000001
800000000000000000000000000000ffff000000000000000000000000000001
800000000000000000000000000000ffff000000000000000000000000000001
800000000000000000000000000000ffff000000000000000000000000000001
800000000000000000000000000000ffff000000000000000000000000000001
800000000000000000000000000000ffff000000000000000000000000000001
800000000000000000000000000000ffff000000000000000000000000000001
800000000000000000000000000000ffff000000000000000000000000000001
800000000000000000000000000000ffff000000000000000000000000000001
8000000000000000000000000000000000000000000000000000000000000001
8000000000000000000000000000000000000000000000000000000000000001
8000000000000000000000000000000000000000000000000000000000000001
8000000000000000000000000000000000000000000000000000000000000001
8000000000000000000000000000000000000000000000000000000000000001
8000000000000000000000000000000000000000000000000000000000000001
8000000000000000000000000000000000000000000000000000000000000001
8000000000000000000000000000000000000000000000000000000000000001
8000000000000000000000000000000000000000000000000000000000000001
8000000000000000000000000000000000000000000000000000000000000001
8000000000000000000000000000000000000000000000000000000000000001
8000000000000000000000000000000000000000000000000000000000000001
8000000000000000000000000000000000000000000000000000000000000001
8000000000000000000000000000000000000000000000000000000000000001
ffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffff
ffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffff

/* filelist.f */
rtl/alarm_overlay_pkg.sv
rtl/overlay_window.sv
rtl/glyph_rom.sv
rtl/pixel_pick.sv
rtl/alarm_overlay.sv
bench/alarm_overlay_assertions.sv
bench/alarm_overlay_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= alarm_overlay_tb
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
IMAGE     ?= rtl/alarm_image.mem
VFLAGS    ?= --binary --timing --assert -Wno-fatal
LINTFLAGS ?= --lint-only --timing -Wall

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

# the ROM loads its image by bare file name from the run directory
alarm_image.mem: $(IMAGE)
	cp $(IMAGE) alarm_image.mem

run: build alarm_image.mem
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	@if grep -q "TB FAILED" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q "TB PASSED" $(LOG); then echo "simulation did not complete"; exit 1; fi

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG) alarm_image.mem
